//--- verilog/cpu_int_pkg.sv
package cpu_int_pkg;

    // Opcodes live in the top five bits of every instruction word
    localparam logic [4:0] OPC_NOP  = 5'b01111;
    localparam logic [4:0] OPC_JUMP = 5'b10100;
    localparam logic [4:0] OPC_RETI = 5'b11111;

    localparam logic [31:0] INSTR_NOOP = {OPC_NOP, 27'd0}; // 32'h78000000

    localparam logic [31:0] PC_RESET = 32'h0600_2000; // Start of instruction memory

    // Handler table, one entry per vector
    localparam logic [31:0] VEC_BASE   = 32'h0600_0000;
    localparam logic [31:0] VEC_STRIDE = 32'h0000_0040;

    // Pipeline clear length in no-op cycles
    localparam int                CNT_W     = 3;
    localparam logic [CNT_W-1:0] CLEAR_LEN = 3'd5;

    typedef enum logic [2:0] {
        ST_NORMAL,    // Memory fetch
        ST_CLEAR_INT, // No-ops before save
        ST_SAVE,      // Capture special regs
        ST_ACK,       // Acknowledge to controller
        ST_INJECT,    // Controller drives the stream
        ST_CLEAR_RET, // No-ops after RETI
        ST_RESTORE    // Reload PC and special regs
    } int_state_t;

    // Same 32 bits seen as a plain opcode word or as an absolute jump
    typedef union packed {
        struct packed {
            logic [4:0]  opcode;
            logic [26:0] payload;
        } gen;
        struct packed {
            logic [4:0]  opcode;
            logic [26:0] target; // Zero-extended into the PC
        } jmp;
    } instr_u;

endpackage

//--- verilog/cpu_interrupt_fsm.sv
module cpu_interrupt_fsm
    import cpu_int_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        int_line,          // Pending interrupt from controller
    input  logic [31:0] int_instr,         // Controller's injected word
    input  logic [31:0] mem_instr,         // Word fetched from memory at pc
    output logic        ack,               // One-cycle acknowledge
    output logic        save,              // Capture special regs
    output logic        restore,           // Reload special regs and PC
    output logic        use_cpu_injection, // Select cpu_injection in fetch
    output logic        use_int_instr,     // Select int_instr in fetch
    output logic [31:0] cpu_injection
);

    int_state_t       state;
    int_state_t       next_state;
    logic [CNT_W-1:0] clr_cnt;   // No-op cycles spent in the current clear
    logic             clearing;
    logic             clr_done;
    instr_u           int_w;
    instr_u           mem_w;
    logic             is_reti;
    logic             int_jump;

    assign int_w = int_instr;
    assign mem_w = mem_instr;

    assign is_reti  = (mem_w.gen.opcode == OPC_RETI);
    assign int_jump = (int_w.jmp.opcode == OPC_JUMP); // Handler jump ends injection

    assign clearing = (state == ST_CLEAR_INT) || (state == ST_CLEAR_RET);
    assign clr_done = (clr_cnt == CLEAR_LEN - 1'b1);

    assign cpu_injection = INSTR_NOOP; // Only ever a no-op from here

    always_comb begin
        next_state        = state;
        ack               = 1'b0;
        save              = 1'b0;
        restore           = 1'b0;
        use_cpu_injection = 1'b0;
        use_int_instr     = 1'b0;

        case (state)
            ST_NORMAL: begin
                if (int_line) begin
                    next_state = ST_CLEAR_INT; // Interrupt wins over a return
                end else if (is_reti) begin
                    use_cpu_injection = 1'b1;  // RETI never reaches decode
                    next_state        = ST_CLEAR_RET;
                end
            end

            ST_CLEAR_INT: begin
                use_cpu_injection = 1'b1;
                if (clr_done) begin
                    next_state = ST_SAVE;
                end
            end

            ST_SAVE: begin
                use_cpu_injection = 1'b1;
                save              = 1'b1; // PC is still held on the replaced instr
                next_state        = ST_ACK;
            end

            ST_ACK: begin
                use_cpu_injection = 1'b1;
                ack               = 1'b1;
                next_state        = ST_INJECT;
            end

            // Controller owns the stream until its jump goes by
            ST_INJECT: begin
                use_int_instr = 1'b1;
                if (int_jump) begin
                    next_state = ST_NORMAL;
                end
            end

            ST_CLEAR_RET: begin
                use_cpu_injection = 1'b1;
                if (clr_done) begin
                    next_state = ST_RESTORE;
                end
            end

            ST_RESTORE: begin
                use_cpu_injection = 1'b1;
                restore           = 1'b1; // Fetch reloads saved_pc this cycle
                next_state        = ST_NORMAL;
            end

            default: begin
                next_state = ST_NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_NORMAL;
        end else begin
            state <= next_state;
        end
    end

    // Counts only inside a clear, back to zero on exit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clr_cnt <= '0;
        end else if (clearing && !clr_done) begin
            clr_cnt <= clr_cnt + 1'b1;
        end else begin
            clr_cnt <= '0;
        end
    end

endmodule

//--- verilog/int_controller.sv
module int_controller
    import cpu_int_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        int_req,    // Request level from outside
    input  logic [1:0]  int_vector, // Sampled on the rising edge of int_req
    input  logic        ack,        // From the FSM
    output logic        int_line,
    output logic [31:0] int_instr
);

    logic        req_q;       // Previous int_req for edge detect
    logic        req_rise;
    logic        take_req;
    logic        pending;
    logic        jmp_q;       // Jump goes out this cycle
    logic [1:0]  vec_q;       // Vector of the pending request
    logic [1:0]  jmp_vec;     // Vector being serviced
    logic [26:0] handler_tgt;
    instr_u      jump_w;

    assign req_rise = int_req & ~req_q;
    assign take_req = req_rise & (~pending | ack); // Ignore while one is pending

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= 1'b0;
            pending <= 1'b0;
            jmp_q   <= 1'b0;
        end else begin
            req_q <= int_req;
            jmp_q <= ack;
            if (take_req) begin
                pending <= 1'b1;
            end else if (ack) begin
                pending <= 1'b0;
            end
        end
    end

    // Latched vector and the one being serviced
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vec_q   <= 2'd0;
            jmp_vec <= 2'd0;
        end else begin
            if (take_req) begin
                vec_q <= int_vector;
            end
            if (ack) begin
                jmp_vec <= vec_q; // Frees vec_q for a nested request
            end
        end
    end

    // Low from ack until the jump is out so a new request waits for normal
    assign int_line = pending & ~ack & ~jmp_q;

    assign handler_tgt = 27'(VEC_BASE + ({30'd0, jmp_vec} * VEC_STRIDE));

    always_comb begin
        jump_w.jmp.opcode = OPC_JUMP;
        jump_w.jmp.target = handler_tgt;
    end

    assign int_instr = jmp_q ? jump_w : INSTR_NOOP;

endmodule

//--- verilog/special_reg_save.sv
module special_reg_save
    import cpu_int_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        save,       // One-cycle strobe from the FSM
    input  logic [31:0] pc,         // Held fetch PC
    input  logic [31:0] cur_lr,     // LR as seen in decode
    input  logic [1:0]  cur_fl,     // Flags as seen in decode
    output logic [31:0] saved_pc,
    output logic [31:0] lr_restore,
    output logic [1:0]  fl_restore
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_pc   <= PC_RESET;
            lr_restore <= PC_RESET;
            fl_restore <= 2'b00;    // No flags set
        end else if (save) begin
            saved_pc   <= pc;
            lr_restore <= cur_lr;
            fl_restore <= cur_fl;
        end
    end

endmodule

//--- verilog/fetch_stage.sv
module fetch_stage
    import cpu_int_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] mem_instr,
    input  logic        use_cpu_injection,
    input  logic [31:0] cpu_injection,
    input  logic        use_int_instr,
    input  logic [31:0] int_instr,
    input  logic        restore,           // Reload PC from the save bank
    input  logic [31:0] saved_pc,
    output logic [31:0] pc,
    output logic [31:0] instr_out          // Selected word, one cycle late
);

    instr_u sel_w;
    logic   inject; // Any injected source selected

    assign inject = use_int_instr | use_cpu_injection;

    always_comb begin
        if (use_int_instr) begin
            sel_w = int_instr;
        end else if (use_cpu_injection) begin
            sel_w = cpu_injection;
        end else begin
            sel_w = mem_instr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= PC_RESET;
            instr_out <= INSTR_NOOP;
        end else begin
            instr_out <= sel_w;
            if (restore) begin
                pc <= saved_pc;                         // Resume after RETI
            end else if (inject && (sel_w.jmp.opcode == OPC_JUMP)) begin
                pc <= {5'd0, sel_w.jmp.target};         // Handler entry
            end else if (!inject) begin
                pc <= pc + 32'd4;
            end
            // Otherwise hold while no-ops go down the pipe
        end
    end

endmodule

//--- verilog/cpu_int_top.sv
module cpu_int_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        int_req,
    input  logic [1:0]  int_vector,
    input  logic [31:0] mem_instr,  // Instruction memory data at pc
    input  logic [31:0] cur_lr,
    input  logic [1:0]  cur_fl,
    output logic [31:0] pc,
    output logic [31:0] instr_out,
    output logic        int_ack,
    output logic        restore,
    output logic [31:0] lr_restore,
    output logic [1:0]  fl_restore
);

    logic        int_line;
    logic [31:0] int_instr;
    logic        save;
    logic        use_cpu_injection;
    logic        use_int_instr;
    logic [31:0] cpu_injection;
    logic [31:0] saved_pc;

    cpu_interrupt_fsm cpu_interrupt_fsm_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .int_line          (int_line),
        .int_instr         (int_instr),
        .mem_instr         (mem_instr),
        .ack               (int_ack),
        .save              (save),
        .restore           (restore),
        .use_cpu_injection (use_cpu_injection),
        .use_int_instr     (use_int_instr),
        .cpu_injection     (cpu_injection)
    );

    int_controller int_controller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .int_req    (int_req),
        .int_vector (int_vector),
        .ack        (int_ack),
        .int_line   (int_line),
        .int_instr  (int_instr)
    );

    special_reg_save special_reg_save_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .save       (save),
        .pc         (pc),
        .cur_lr     (cur_lr),
        .cur_fl     (cur_fl),
        .saved_pc   (saved_pc),
        .lr_restore (lr_restore),
        .fl_restore (fl_restore)
    );

    fetch_stage fetch_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_instr         (mem_instr),
        .use_cpu_injection (use_cpu_injection),
        .cpu_injection     (cpu_injection),
        .use_int_instr     (use_int_instr),
        .int_instr         (int_instr),
        .restore           (restore),
        .saved_pc          (saved_pc),
        .pc                (pc),
        .instr_out         (instr_out)
    );

endmodule

//--- verification/cpu_int_tb.sv
module cpu_int_tb
    import cpu_int_pkg::*;
();

    localparam logic [31:0] SEED_INIT   = 32'hd5a6f564;
    localparam int          ENTRY_LIMIT = 30; // One entry takes about ten cycles
    localparam int          RET_LIMIT   = 20;

    logic        clk, rst_n, int_req, int_ack, restore;
    logic [1:0]  int_vector, cur_fl, fl_restore;
    logic [31:0] mem_instr, cur_lr, pc, instr_out, lr_restore;

    integer      seed;
    int          err_cnt, check_cnt, test_cnt, fail_cnt, test_errs;
    string       cur_test;
    logic [31:0] entry_pc, save_lr, w, r, exp_pc;
    logic [1:0]  save_fl, vec;

    // Reference model state, advanced once per rising edge
    int_state_t  m_state;
    int          m_left;                          // Clear cycles still to go
    logic [31:0] m_pc, m_instr, m_saved_pc, m_lr;
    logic [1:0]  m_fl, m_vec, m_jvec;             // Pending and serviced vectors
    logic        m_pending, m_jmp, m_req_q;

    cpu_int_top cpu_int_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] handler_addr(input logic [1:0] v);
        return VEC_BASE + ({30'd0, v} * VEC_STRIDE);
    endfunction

    function automatic logic [31:0] jump_word(input logic [1:0] v);
        logic [31:0] h;
        h = handler_addr(v);
        return {OPC_JUMP, h[26:0]}; // Target fits in 27 bits
    endfunction

    // Plain fetch traffic, never a control opcode
    task automatic next_instr(output logic [31:0] word);
        word = $random(seed);
        if (word[31:27] == OPC_RETI || word[31:27] == OPC_JUMP) word[31] = 1'b0;
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic step_model();
        logic        ack_now, line, inj, take;
        logic [31:0] sel;
        int_state_t  nxt;
        ack_now = (m_state == ST_ACK);
        line    = m_pending && !ack_now && !m_jmp; // Quiet from ack until the jump
        inj     = 1'b1;
        sel     = INSTR_NOOP;
        nxt     = m_state;
        case (m_state)
            ST_NORMAL: begin
                if (!line && mem_instr[31:27] == OPC_RETI) begin
                    nxt    = ST_CLEAR_RET; // RETI itself is replaced
                    m_left = int'(CLEAR_LEN);
                end else begin
                    inj = 1'b0;
                    sel = mem_instr;
                    if (line) begin
                        nxt    = ST_CLEAR_INT;
                        m_left = int'(CLEAR_LEN);
                    end
                end
            end
            ST_CLEAR_INT, ST_CLEAR_RET: begin
                m_left--;
                if (m_left == 0) nxt = (m_state == ST_CLEAR_INT) ? ST_SAVE : ST_RESTORE;
            end
            ST_SAVE: begin
                m_saved_pc = m_pc;                 // PC held on the replaced word
                m_lr       = cur_lr;
                m_fl       = cur_fl;
                nxt        = ST_ACK;
            end
            ST_ACK: nxt = ST_INJECT;
            ST_INJECT: begin
                sel = m_jmp ? jump_word(m_jvec) : INSTR_NOOP;
                if (sel[31:27] == OPC_JUMP) nxt = ST_NORMAL;
            end
            default: nxt = ST_NORMAL;              // Restore lasts one cycle
        endcase
        if (m_state == ST_RESTORE) m_pc = m_saved_pc;
        else if (inj && sel[31:27] == OPC_JUMP) m_pc = {5'd0, sel[26:0]};
        else if (!inj) m_pc = m_pc + 32'd4;
        // Controller model where a new request counts only on a rising edge
        take = int_req && !m_req_q && (!m_pending || ack_now);
        if (ack_now) m_jvec = m_vec;
        if (take) m_vec = int_vector;
        if (take) m_pending = 1'b1;
        else if (ack_now) m_pending = 1'b0;
        m_jmp   = ack_now;
        m_req_q = int_req;
        m_instr = sel;
        m_state = nxt;
    endtask

    task automatic compare_outputs();
        check("pc", m_pc, pc);
        check("instr_out", m_instr, instr_out);
        check("int_ack", 32'(m_state == ST_ACK), 32'(int_ack));
        check("restore", 32'(m_state == ST_RESTORE), 32'(restore));
        check("lr_restore", m_lr, lr_restore);
        check("fl_restore", 32'(m_fl), 32'(fl_restore));
    endtask

    // Called at a falling edge and returns at the next one with outputs checked
    task automatic cycle(input logic req, input logic [1:0] v, input logic [31:0] instr);
        logic [31:0] rnd;
        rnd        = $random(seed);
        int_req    = req;
        int_vector = v;
        mem_instr  = instr;
        cur_lr     = $random(seed);
        cur_fl     = rnd[1:0];
        step_model();
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic idle(input int n);
        logic [31:0] word;
        repeat (n) begin
            next_instr(word);
            cycle(1'b0, 2'd0, word);
        end
    endtask

    // Runs one entry up to the handler jump and may raise a second request at ack
    task automatic follow_entry(input logic [1:0] v, input logic nest, input logic [1:0] nv);
        logic [31:0] word;
        logic        req;
        int          nops, acks, n;
        nops = 0;
        acks = 0;
        n    = 0;
        req  = 1'b0;
        do begin
            next_instr(word);
            cycle(req, nv, word);
            req = 1'b0;
            if (int_ack) begin
                acks++;
                entry_pc = m_saved_pc; // Save cycle has just passed
                save_lr  = cur_lr;
                save_fl  = cur_fl;
                req      = nest;
            end
            if (instr_out == INSTR_NOOP) nops++;
            else if (instr_out[31:27] != OPC_JUMP) nops = 0;
            n++;
        end while (instr_out[31:27] != OPC_JUMP && n < ENTRY_LIMIT);
        if (instr_out[31:27] != OPC_JUMP) begin
            err_cnt++;
            $display("%s: timed out waiting for the handler jump", cur_test);
        end else begin
            check("no-op run", 32'(CLEAR_LEN) + 32'd2, 32'(nops)); // Clear, save, ack
            check("ack pulses", 32'd1, 32'(acks));
            check("jump word", jump_word(v), instr_out);
            check("handler pc", handler_addr(v), pc);
        end
    endtask

    task automatic follow_return();
        logic [31:0] word;
        int          n;
        word = $random(seed);
        cycle(1'b0, 2'd0, {OPC_RETI, word[26:0]});
        n = 1;
        while (!restore && n < RET_LIMIT) begin
            next_instr(word);
            cycle(1'b0, 2'd0, word);
            n++;
        end
        if (!restore) begin
            err_cnt++;
            $display("%s: timed out waiting for restore", cur_test);
        end else begin
            check("return cycles", 32'(CLEAR_LEN) + 32'd1, 32'(n));
            idle(1);                                 // PC reloads as restore ends
            check("resumed pc", entry_pc, pc);
            check("saved lr", save_lr, lr_restore);
            check("saved fl", 32'(save_fl), 32'(fl_restore));
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        if (err_cnt == test_errs) begin
            $display("%s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: FAILED with %0d errors", cur_test, err_cnt - test_errs);
        end
    endtask

    initial begin
        seed       = SEED_INIT;
        clk        = 1'b0;
        rst_n      = 1'b0;
        int_req    = 1'b0;
        int_vector = 2'd0;
        mem_instr  = INSTR_NOOP;
        cur_lr     = 32'd0;
        cur_fl     = 2'd0;
        {err_cnt, check_cnt, test_cnt, fail_cnt} = '0;
        m_state    = ST_NORMAL;
        m_left     = 0;
        {m_pc, m_saved_pc, m_lr} = {3{PC_RESET}};
        m_instr    = INSTR_NOOP;
        {m_fl, m_vec, m_jvec}    = '0;
        {m_pending, m_jmp, m_req_q} = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test("reset_fetch");
        check("reset pc", PC_RESET, pc);
        check("reset instr_out", INSTR_NOOP, instr_out);
        check("reset int_ack", 32'd0, 32'(int_ack));
        check("reset restore", 32'd0, 32'(restore));
        exp_pc = PC_RESET;
        repeat (8) begin
            next_instr(w);
            cycle(1'b0, 2'd0, w);
            exp_pc = exp_pc + 32'd4;
            check("pc step", exp_pc, pc);
            check("fetched word", w, instr_out);
        end
        end_test();

        begin_test("int_entry");
        r = $random(seed);
        vec = r[1:0];
        next_instr(w);
        cycle(1'b1, vec, w);
        follow_entry(vec, 1'b0, 2'd0);
        end_test();

        begin_test("reti_return");
        idle(3);
        follow_return();
        end_test();

        begin_test("priority");
        r = $random(seed);
        vec = r[1:0];
        next_instr(w);
        cycle(1'b1, vec, w);                  // Line is up from the next cycle
        cycle(1'b0, 2'd0, {OPC_RETI, 27'd0}); // RETI meets the pending interrupt
        follow_entry(vec, 1'b0, 2'd0);
        end_test();

        begin_test("nesting");
        r = $random(seed);
        vec = r[1:0];
        next_instr(w);
        cycle(1'b1, vec, w);
        follow_entry(vec, 1'b1, ~vec);        // Second vector differs from the first
        follow_entry(~vec, 1'b0, 2'd0);
        end_test();

        begin_test("random_run");
        repeat (200) begin
            r = $random(seed);
            next_instr(w);
            if (r[7:5] == 3'd0) w = {OPC_RETI, w[26:0]};
            cycle(r[4:2] == 3'd0, r[1:0], w);
        end
        end_test();

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 test_cnt, fail_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/cpu_int_pkg.sv
verilog/cpu_interrupt_fsm.sv
verilog/int_controller.sv
verilog/special_reg_save.sv
verilog/fetch_stage.sv
verilog/cpu_int_top.sv
verification/cpu_int_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run by the testbench verdict line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module cpu_int_tb -f flist.f &&
./obj_dir/Vcpu_int_tb | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation run ok" ||
{ echo "simulation run did not pass"; exit 1; }
